//--- source/apb_ss_bus_pkg.sv
//============================================================================
// AHB-Lite and APB bus vector types and response codes
// Word-only subsystem: HSIZE_WORD is the single legal transfer size
// Only OKAY and ERROR responses are produced, no RETRY or SPLIT
//============================================================================
`default_nettype none

package apb_ss_bus_pkg;

  // ==========================================================================
  // Bus vectors
  // ==========================================================================
  typedef logic [31:0] haddr_t;   // Byte address, AHB and APB
  typedef logic [31:0] hdata_t;   // Read and write data
  typedef logic [1:0]  htrans_t;  // Transfer type
  typedef logic [2:0]  hsize_t;   // Transfer size
  typedef logic [1:0]  hresp_t;   // Slave response

  // Transfer types
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  localparam hsize_t HSIZE_WORD = 3'b010;  // 32-bit access

  // Responses
  localparam hresp_t HRESP_OKAY  = 2'b00;
  localparam hresp_t HRESP_ERROR = 2'b01;

endpackage

`default_nettype wire

//--- source/apb_ss_periph_pkg.sv
//============================================================================
// Address map and register offsets of the APB peripherals
// Each peripheral owns a 256-byte window selected by address bits 11..8
// Any set address bit above bit 11 is unmapped
//============================================================================
`default_nettype none

package apb_ss_periph_pkg;

  typedef logic [7:0] paddr_t;     // Offset inside one window
  typedef logic [3:0] psel_idx_t;  // Window index, address bits 11..8

  // ==========================================================================
  // Window select values
  // ==========================================================================
  localparam psel_idx_t PSEL_GPIO  = 4'd0;
  localparam psel_idx_t PSEL_TIMER = 4'd1;

  // GPIO registers
  localparam paddr_t GPIO_OUT      = 8'h00;  // R/W pin output value
  localparam paddr_t GPIO_OE       = 8'h04;  // R/W, 1 drives the pin
  localparam paddr_t GPIO_IN       = 8'h08;  // RO synchronised pins
  localparam paddr_t GPIO_IRQ_STAT = 8'h0C;  // W1C rising-edge status
  localparam paddr_t GPIO_IRQ_MASK = 8'h10;  // R/W interrupt mask

  // Timer registers
  localparam paddr_t TMR_CTRL     = 8'h00;  // Bit 0 enable, bit 1 auto-reload
  localparam paddr_t TMR_LOAD     = 8'h04;  // Reload value
  localparam paddr_t TMR_COUNT    = 8'h08;  // RO current count
  localparam paddr_t TMR_IRQ_STAT = 8'h0C;  // Bit 0, W1C

endpackage

`default_nettype wire

//--- source/ahb_to_apb_bridge.sv
//============================================================================
// AHB-Lite slave to APB bridge, one APB transfer per AHB beat
// Bursts are served beat by beat, no wait states on the APB side
// Non-word sizes and unmapped addresses get a two-cycle ERROR, no APB cycle
// Read data comes 3 cycles after the address phase, HREADY low for two
//============================================================================
`default_nettype none
`timescale 1ns/1ps

module ahb_to_apb_bridge
  import apb_ss_bus_pkg::*;
  import apb_ss_periph_pkg::*;
(
  input  logic    tb_hclk20,
  input  logic    hresetn20,
  // AHB-Lite slave side
  input  haddr_t  i_haddr,
  input  htrans_t i_htrans,
  input  hsize_t  i_hsize,
  input  logic    i_hwrite,
  input  hdata_t  i_hwdata,
  output hdata_t  o_hrdata,
  output logic    o_hready,
  output hresp_t  o_hresp,
  // APB master side
  input  hdata_t  i_prdata_gpio,
  input  hdata_t  i_prdata_timer,
  output paddr_t  o_paddr,
  output logic    o_pwrite,
  output hdata_t  o_pwdata,
  output logic    o_penable,
  output logic    o_psel_gpio,
  output logic    o_psel_timer
);

  typedef enum logic [2:0] {
    ST_IDLE,    // Ready, waiting for an address phase
    ST_SETUP,   // APB setup, psel only
    ST_ACCESS,  // APB access, psel and penable
    ST_ERR1,    // First error cycle, hready low
    ST_ERR2     // Second error cycle, hready high
  } br_state_t;

  br_state_t state_q, state_d;

  logic   trans_valid;  // NONSEQ or SEQ
  logic   accept;       // Address phase taken this cycle
  logic   hit_gpio, hit_timer;
  logic   map_ok, size_ok, go;
  logic   sel_gpio_q, sel_timer_q;
  logic   apb_phase;
  paddr_t addr_q;
  logic   write_q;
  hdata_t rdata_q;
  hdata_t prdata_sel;

  // ==========================================================================
  // Address phase decode, the only place the map and size are checked
  // ==========================================================================
  assign trans_valid = (i_htrans == HTRANS_NONSEQ) || (i_htrans == HTRANS_SEQ);
  assign accept      = o_hready && trans_valid;  // IDLE and BUSY ignored
  assign hit_gpio    = (i_haddr[11:8] == PSEL_GPIO);
  assign hit_timer   = (i_haddr[11:8] == PSEL_TIMER);
  assign map_ok      = (i_haddr[31:12] == '0) && (hit_gpio || hit_timer);
  assign size_ok     = (i_hsize == HSIZE_WORD);
  assign go          = map_ok && size_ok;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_ERR2: begin  // Both cycles can take a new address phase
        if (accept) begin
          state_d = go ? ST_SETUP : ST_ERR1;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_SETUP:  state_d = ST_ACCESS;
      ST_ACCESS: state_d = ST_IDLE;
      ST_ERR1:   state_d = ST_ERR2;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge tb_hclk20) begin
    if (!hresetn20) begin
      state_q     <= ST_IDLE;
      sel_gpio_q  <= 1'b0;
      sel_timer_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        sel_gpio_q  <= go && hit_gpio;   // Held through setup and access
        sel_timer_q <= go && hit_timer;
      end
    end
  end

  // Read data mux, by the select we drove
  always_comb begin
    if (sel_gpio_q) begin
      prdata_sel = i_prdata_gpio;
    end else if (sel_timer_q) begin
      prdata_sel = i_prdata_timer;
    end else begin
      prdata_sel = '0;
    end
  end

  // Payload, no reset needed
  always_ff @(posedge tb_hclk20) begin
    if (accept) begin
      addr_q  <= i_haddr[7:0];  // Offset inside the window
      write_q <= i_hwrite;
    end
    if (state_q == ST_ACCESS && !write_q) begin
      rdata_q <= prdata_sel;  // Returned in the cycle after access
    end
  end

  // ==========================================================================
  // Outputs
  // ==========================================================================
  assign apb_phase    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign o_hready     = (state_q == ST_IDLE) || (state_q == ST_ERR2);
  assign o_hresp      = (state_q == ST_ERR1 || state_q == ST_ERR2) ? HRESP_ERROR
                                                                   : HRESP_OKAY;
  assign o_hrdata     = rdata_q;
  assign o_paddr      = addr_q;
  assign o_pwrite     = write_q;
  assign o_pwdata     = i_hwdata;  // Master holds it while hready is low
  assign o_penable    = (state_q == ST_ACCESS);
  assign o_psel_gpio  = apb_phase && sel_gpio_q;
  assign o_psel_timer = apb_phase && sel_timer_q;

  // Access cycle must follow a setup cycle with psel alone
  a_penable_after_setup : assert property (@(posedge tb_hclk20) disable iff (!hresetn20)
    o_penable |-> $past(o_psel_gpio || o_psel_timer) && !$past(o_penable))
    else $error("penable without a preceding APB setup cycle");

  a_psel_onehot : assert property (@(posedge tb_hclk20) disable iff (!hresetn20)
    $onehot0({o_psel_gpio, o_psel_timer}))
    else $error("more than one APB select active");

endmodule

`default_nettype wire

//--- source/apb_gpio.sv
//============================================================================
// APB GPIO, GPIO_WIDTH pins, no wait states
// Inputs pass a two-flop synchroniser, GPIO_IN lags the pins by 2 cycles
// Rising edges set sticky status bits, write ones to clear
//============================================================================
`default_nettype none
`timescale 1ns/1ps

module apb_gpio
  import apb_ss_bus_pkg::*;
  import apb_ss_periph_pkg::*;
#(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  tb_hclk20,
  input  logic                  hresetn20,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  paddr_t                i_paddr,
  input  hdata_t                i_pwdata,
  output hdata_t                o_prdata,
  input  logic [GPIO_WIDTH-1:0] i_gpio_in,
  output logic [GPIO_WIDTH-1:0] o_gpio_out,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe_n,
  output logic                  o_gpio_irq
);

  typedef logic [GPIO_WIDTH-1:0] gpio_vec_t;  // One bit per pin

  gpio_vec_t out_q, oe_q, mask_q, stat_q;
  gpio_vec_t sync1_q, sync2_q, prev_q;
  gpio_vec_t rise;
  gpio_vec_t wdata;
  logic      wr_en;

  assign wr_en = i_psel && i_penable && i_pwrite;  // Access cycle write
  assign wdata = i_pwdata[GPIO_WIDTH-1:0];
  assign rise  = sync2_q & ~prev_q;  // Synchronised rising edges

  // ==========================================================================
  // Registers and input synchroniser
  // ==========================================================================
  always_ff @(posedge tb_hclk20) begin
    if (!hresetn20) begin
      out_q   <= '0;
      oe_q    <= '0;   // All pins released
      mask_q  <= '0;
      stat_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;  // Edge detect history
      if (wr_en && i_paddr == GPIO_OUT)      out_q  <= wdata;
      if (wr_en && i_paddr == GPIO_OE)       oe_q   <= wdata;
      if (wr_en && i_paddr == GPIO_IRQ_MASK) mask_q <= wdata;
      if (wr_en && i_paddr == GPIO_IRQ_STAT) begin
        stat_q <= (stat_q & ~wdata) | rise;  // New edge beats the clear
      end else begin
        stat_q <= stat_q | rise;
      end
    end
  end

  // Read mux, valid in the access cycle
  always_comb begin
    o_prdata = '0;
    if (i_psel && !i_pwrite) begin
      case (i_paddr)
        GPIO_OUT:      o_prdata[GPIO_WIDTH-1:0] = out_q;
        GPIO_OE:       o_prdata[GPIO_WIDTH-1:0] = oe_q;
        GPIO_IN:       o_prdata[GPIO_WIDTH-1:0] = sync2_q;
        GPIO_IRQ_STAT: o_prdata[GPIO_WIDTH-1:0] = stat_q;
        GPIO_IRQ_MASK: o_prdata[GPIO_WIDTH-1:0] = mask_q;
        default:       o_prdata = '0;  // Unmapped offsets read zero
      endcase
    end
  end

  assign o_gpio_out  = out_q;
  assign o_gpio_oe_n = ~oe_q;  // Pads want active-low enables
  assign o_gpio_irq  = |(stat_q & mask_q);

  // Status bits only appear after a synchronised rising edge
  a_stat_needs_edge : assert property (@(posedge tb_hclk20) disable iff (!hresetn20)
    (stat_q & ~$past(stat_q) & ~$past(rise)) == '0)
    else $error("GPIO status bit set without a rising edge");

endmodule

`default_nettype wire

//--- source/apb_timer.sv
//============================================================================
// APB down-counter timer with one interrupt
// Counts once per cycle while enabled, status sets when COUNT is zero
// One-shot clears the enable there, auto-reload restarts from LOAD
// Auto-reload period is LOAD+1 cycles
//============================================================================
`default_nettype none
`timescale 1ns/1ps

module apb_timer
  import apb_ss_bus_pkg::*;
  import apb_ss_periph_pkg::*;
#(
  parameter int TIMER_WIDTH = 16
) (
  input  logic   tb_hclk20,
  input  logic   hresetn20,
  input  logic   i_psel,
  input  logic   i_penable,
  input  logic   i_pwrite,
  input  paddr_t i_paddr,
  input  hdata_t i_pwdata,
  output hdata_t o_prdata,
  output logic   o_timer_irq
);

  typedef logic [TIMER_WIDTH-1:0] tmr_cnt_t;  // Count and reload value

  tmr_cnt_t load_q, count_q;
  logic     en_q, reload_q, stat_q;
  logic     wr_en;
  logic     expire;  // Enabled and at zero this cycle

  assign wr_en  = i_psel && i_penable && i_pwrite;
  assign expire = en_q && (count_q == '0);

  // ==========================================================================
  // Counter and control
  // ==========================================================================
  always_ff @(posedge tb_hclk20) begin
    if (!hresetn20) begin
      load_q   <= '0;
      count_q  <= '0;
      en_q     <= 1'b0;
      reload_q <= 1'b0;
      stat_q   <= 1'b0;
    end else begin
      // Hardware update first, register writes override below
      if (expire) begin
        if (reload_q) count_q <= load_q;
        else          en_q    <= 1'b0;  // One-shot stops
      end else if (en_q) begin
        count_q <= count_q - 1'b1;
      end
      if (wr_en && i_paddr == TMR_CTRL) begin
        en_q     <= i_pwdata[0];
        reload_q <= i_pwdata[1];
      end
      if (wr_en && i_paddr == TMR_LOAD) begin
        load_q  <= i_pwdata[TIMER_WIDTH-1:0];
        count_q <= i_pwdata[TIMER_WIDTH-1:0];  // Restart from new value
      end
      if (wr_en && i_paddr == TMR_IRQ_STAT) begin
        stat_q <= expire | (stat_q & ~i_pwdata[0]);  // Set wins over clear
      end else begin
        stat_q <= expire | stat_q;
      end
    end
  end

  always_comb begin
    o_prdata = '0;
    if (i_psel && !i_pwrite) begin
      case (i_paddr)
        TMR_CTRL:     o_prdata[1:0]             = {reload_q, en_q};
        TMR_LOAD:     o_prdata[TIMER_WIDTH-1:0] = load_q;
        TMR_COUNT:    o_prdata[TIMER_WIDTH-1:0] = count_q;
        TMR_IRQ_STAT: o_prdata[0]               = stat_q;
        default:      o_prdata = '0;
      endcase
    end
  end

  assign o_timer_irq = stat_q;

  a_count_le_load : assert property (@(posedge tb_hclk20) disable iff (!hresetn20)
    en_q |-> count_q <= load_q)
    else $error("timer COUNT above LOAD while enabled");

endmodule

`default_nettype wire

//--- source/apb_subsystem.sv
//============================================================================
// AHB-Lite to APB subsystem, bridge plus GPIO and timer
// Single clock and synchronous active-low reset for all blocks
// One transfer in flight, master must wait for hready
//============================================================================
`default_nettype none
`timescale 1ns/1ps

module apb_subsystem
  import apb_ss_bus_pkg::*;
  import apb_ss_periph_pkg::*;
#(
  parameter int GPIO_WIDTH  = 16,
  parameter int TIMER_WIDTH = 16
) (
  input  logic                  tb_hclk20,
  input  logic                  hresetn20,
  // AHB-Lite slave port
  input  haddr_t                i_haddr,
  input  htrans_t               i_htrans,
  input  hsize_t                i_hsize,
  input  logic                  i_hwrite,
  input  hdata_t                i_hwdata,
  output hdata_t                o_hrdata,
  output logic                  o_hready,
  output hresp_t                o_hresp,
  // Peripheral pins
  input  logic [GPIO_WIDTH-1:0] i_gpio_in,
  output logic [GPIO_WIDTH-1:0] o_gpio_out,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe_n,
  output logic                  o_gpio_irq,
  output logic                  o_timer_irq
);

  // ==========================================================================
  // Internal APB
  // ==========================================================================
  paddr_t paddr;
  logic   pwrite, penable;
  logic   psel_gpio, psel_timer;
  hdata_t pwdata;
  hdata_t prdata_gpio, prdata_timer;  // One return bus per peripheral

  ahb_to_apb_bridge u_bridge (
    .tb_hclk20      (tb_hclk20),
    .hresetn20      (hresetn20),
    .i_haddr        (i_haddr),
    .i_htrans       (i_htrans),
    .i_hsize        (i_hsize),
    .i_hwrite       (i_hwrite),
    .i_hwdata       (i_hwdata),
    .o_hrdata       (o_hrdata),
    .o_hready       (o_hready),
    .o_hresp        (o_hresp),
    .i_prdata_gpio  (prdata_gpio),
    .i_prdata_timer (prdata_timer),
    .o_paddr        (paddr),
    .o_pwrite       (pwrite),
    .o_pwdata       (pwdata),
    .o_penable      (penable),
    .o_psel_gpio    (psel_gpio),
    .o_psel_timer   (psel_timer)
  );

  apb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
    .tb_hclk20   (tb_hclk20),
    .hresetn20   (hresetn20),
    .i_psel      (psel_gpio),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata_gpio),
    .i_gpio_in   (i_gpio_in),
    .o_gpio_out  (o_gpio_out),
    .o_gpio_oe_n (o_gpio_oe_n),
    .o_gpio_irq  (o_gpio_irq)
  );

  apb_timer #(.TIMER_WIDTH(TIMER_WIDTH)) u_timer (
    .tb_hclk20   (tb_hclk20),
    .hresetn20   (hresetn20),
    .i_psel      (psel_timer),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata_timer),
    .o_timer_irq (o_timer_irq)
  );

endmodule

`default_nettype wire

//--- verif/apb_subsystem_checker.sv
//============================================================================
// Result checker, samples DUT outputs on the rising edge
// Fixed 16-pin layout, pin compare value is {oe_n, out}
// Interrupt compare value is {timer_irq, gpio_irq} in bits 1..0
// Data phase must end 3 cycles after the address phase, 2 for ERROR
//============================================================================
`default_nettype none
`timescale 1ns/1ps

module apb_subsystem_checker
  import apb_ss_bus_pkg::*;
#(
  parameter int NAME_BYTES = 24
) (
  input  logic                    tb_hclk20,
  input  logic                    hresetn20,
  input  htrans_t                 i_htrans,
  input  logic                    i_hready,
  input  hresp_t                  i_hresp,
  input  hdata_t                  i_hrdata,
  input  logic [15:0]             i_gpio_out,
  input  logic [15:0]             i_gpio_oe_n,
  input  logic                    i_gpio_irq,
  input  logic                    i_timer_irq,
  input  logic [2:0]              i_kind,     // From the driver
  input  hdata_t                  i_exp,
  input  logic [8*NAME_BYTES-1:0] i_name,
  input  logic                    i_pin_chk,  // Compare pins this edge
  output int                      o_tests,
  output int                      o_errors
);

  localparam logic [2:0] K_RD   = 3'd0;
  localparam logic [2:0] K_WR   = 3'd1;
  localparam logic [2:0] K_ERR  = 3'd2;
  localparam logic [2:0] K_PINS = 3'd3;

  logic                    busy;    // Transfer between address and end of data
  logic [2:0]              p_kind;
  hdata_t                  p_exp;
  logic [8*NAME_BYTES-1:0] p_name;
  int                      lat;       // Cycles since the address phase
  int                      exp_lat;   // AHB latency for this kind
  hresp_t                  exp_resp;
  hdata_t                  pins_now, irq_now;
  int                      n_tests  = 0;
  int                      n_errors = 0;

  assign pins_now = {i_gpio_oe_n, i_gpio_out};
  assign irq_now  = {30'd0, i_timer_irq, i_gpio_irq};
  assign exp_lat  = (p_kind == K_ERR) ? 2 : 3;
  assign exp_resp = (p_kind == K_ERR) ? HRESP_ERROR : HRESP_OKAY;
  assign o_tests  = n_tests;
  assign o_errors = n_errors;

  task automatic check_value(input logic [8*NAME_BYTES-1:0] name, input hdata_t exp,
                             input hdata_t act);
    n_tests++;
    if (act === exp) begin
      $display("[PASS] %0s", name);
    end else begin
      n_errors++;
      $display("[FAIL] %0s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_resp(input logic [8*NAME_BYTES-1:0] name, input hresp_t want,
                            input string what);
    n_tests++;
    if (i_hresp === want) begin
      $display("[PASS] %0s", name);
    end else begin
      n_errors++;
      $display("[FAIL] %0s: %s", name, what);
    end
  endtask

  task automatic report_latency_fail(input logic [8*NAME_BYTES-1:0] name, input int exp,
                                     input int act);
    n_tests++;
    n_errors++;
    $display("[FAIL] %0s: expected latency %0d cycles, actual %0d", name, exp, act);
  endtask

  // ==========================================================================
  // Sampling, all values are the ones of the cycle that just ended
  // ==========================================================================
  always @(posedge tb_hclk20) begin
    if (!hresetn20) begin
      busy <= 1'b0;
      lat  <= 0;
    end else begin
      if (busy) begin
        lat <= lat + 1;  // One more cycle of the data phase
      end
      if (busy && i_hready) begin  // Data phase ends here
        busy <= 1'b0;
        if (i_hresp === exp_resp && lat != exp_lat) begin
          report_latency_fail(p_name, exp_lat, lat);
        end else if (p_kind == K_RD && i_hresp === HRESP_OKAY) begin
          check_value(p_name, p_exp, i_hrdata);
        end else if (p_kind == K_RD) begin
          check_resp(p_name, HRESP_OKAY, "read was answered with ERROR");
        end else if (p_kind == K_WR) begin
          check_resp(p_name, HRESP_OKAY, "write was answered with ERROR");
        end else if (p_kind == K_ERR) begin
          check_resp(p_name, HRESP_ERROR, "transfer was not answered with ERROR");
        end
      end
      if (i_hready && (i_htrans == HTRANS_NONSEQ || i_htrans == HTRANS_SEQ)) begin
        busy   <= 1'b1;  // Address phase accepted
        lat    <= 1;
        p_kind <= i_kind;
        p_exp  <= i_exp;
        p_name <= i_name;
      end
      if (i_pin_chk) begin
        check_value(i_name, i_exp, (i_kind == K_PINS) ? pins_now : irq_now);
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/apb_subsystem_tb_top.sv
//============================================================================
// Testbench top for the AHB-Lite to APB subsystem, single AHB master
// Commands come from verif/apb_subsystem_stimulus.txt, run from project root
// Inputs change 1 ns after the rising edge, one transfer in flight
// Watchdog allows 20 cycles per command plus every wait cycle
//============================================================================
`default_nettype none
`timescale 1ns/1ps

module apb_subsystem_tb_top
  import apb_ss_bus_pkg::*;
();

  localparam int    CLK_PERIOD   = 40;
  localparam int    DRIVE_DLY    = 1;   // Skew after the rising edge
  localparam int    RESET_CYCLES = 8;
  localparam int    MAX_CMDS     = 64;
  localparam int    NAME_BYTES   = 24;  // Longest test name
  localparam int    GPIO_WIDTH   = 16;
  localparam string STIM_FILE    = "verif/apb_subsystem_stimulus.txt";

  // Check kinds, same codes as in the checker
  localparam logic [2:0] K_RD   = 3'd0;
  localparam logic [2:0] K_WR   = 3'd1;
  localparam logic [2:0] K_ERR  = 3'd2;
  localparam logic [2:0] K_PINS = 3'd3;
  localparam logic [2:0] K_IRQ  = 3'd4;

  logic                    tb_hclk20, hresetn20;
  haddr_t                  haddr;
  htrans_t                 htrans;
  hsize_t                  hsize;
  logic                    hwrite;
  hdata_t                  hwdata, hrdata;
  logic                    hready;
  hresp_t                  hresp;
  logic [GPIO_WIDTH-1:0]   gpio_in, gpio_out, gpio_oe_n;
  logic                    gpio_irq, timer_irq;
  // Expectation handed to the checker
  logic [2:0]              chk_kind;
  hdata_t                  chk_exp;
  logic [8*NAME_BYTES-1:0] chk_name;
  logic                    pin_chk;
  int                      n_tests, n_errors;

  // Command table, filled before reset is released
  string                   cmd_op   [MAX_CMDS];
  haddr_t                  cmd_addr [MAX_CMDS];
  hdata_t                  cmd_data [MAX_CMDS];
  hdata_t                  cmd_exp  [MAX_CMDS];
  logic [8*NAME_BYTES-1:0] cmd_name [MAX_CMDS];
  int                      n_cmds     = 0;
  int                      wait_total = 0;
  int                      bad_cmds   = 0;
  int                      wd_limit   = 0;  // Zero until the file is read

  apb_subsystem #(.GPIO_WIDTH(GPIO_WIDTH), .TIMER_WIDTH(16)) UUT (
    .tb_hclk20   (tb_hclk20),
    .hresetn20   (hresetn20),
    .i_haddr     (haddr),
    .i_htrans    (htrans),
    .i_hsize     (hsize),
    .i_hwrite    (hwrite),
    .i_hwdata    (hwdata),
    .o_hrdata    (hrdata),
    .o_hready    (hready),
    .o_hresp     (hresp),
    .i_gpio_in   (gpio_in),
    .o_gpio_out  (gpio_out),
    .o_gpio_oe_n (gpio_oe_n),
    .o_gpio_irq  (gpio_irq),
    .o_timer_irq (timer_irq)
  );

  apb_subsystem_checker #(.NAME_BYTES(NAME_BYTES)) u_checker (
    .tb_hclk20   (tb_hclk20),
    .hresetn20   (hresetn20),
    .i_htrans    (htrans),
    .i_hready    (hready),
    .i_hresp     (hresp),
    .i_hrdata    (hrdata),
    .i_gpio_out  (gpio_out),
    .i_gpio_oe_n (gpio_oe_n),
    .i_gpio_irq  (gpio_irq),
    .i_timer_irq (timer_irq),
    .i_kind      (chk_kind),
    .i_exp       (chk_exp),
    .i_name      (chk_name),
    .i_pin_chk   (pin_chk),
    .o_tests     (n_tests),
    .o_errors    (n_errors)
  );

  initial begin
    tb_hclk20 = 1'b0;
    forever #(CLK_PERIOD/2) tb_hclk20 = ~tb_hclk20;
  end

  // ==========================================================================
  // Stimulus file reader
  // ==========================================================================
  task automatic load_stimulus(output logic ok);
    int                      fd;
    int                      n;
    string                   line;
    string                   op;
    haddr_t                  a;
    hdata_t                  d;
    hdata_t                  e;
    logic [8*NAME_BYTES-1:0] nm;
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and notes
          n = $sscanf(line, "%s %h %h %h %s", op, a, d, e, nm);
          if (n == 5 && n_cmds < MAX_CMDS) begin
            cmd_op[n_cmds]   = op;
            cmd_addr[n_cmds] = a;
            cmd_data[n_cmds] = d;
            cmd_exp[n_cmds]  = e;
            cmd_name[n_cmds] = nm;
            if (op == "wait") wait_total += d;
            n_cmds++;
          end else begin
            $display("Malformed stimulus line: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
    if (n_cmds == 0) ok = 1'b0;
  endtask

  // One AHB transfer, entered DRIVE_DLY after an edge
  task automatic ahb_transfer(input haddr_t addr, input logic write, input hsize_t size,
                              input hdata_t wdata, input logic [2:0] kind,
                              input hdata_t exp, input logic [8*NAME_BYTES-1:0] name);
    haddr    = addr;              // Address phase
    htrans   = HTRANS_NONSEQ;
    hsize    = size;
    hwrite   = write;
    chk_kind = kind;              // Checker latches these with the address
    chk_exp  = exp;
    chk_name = name;
    while (!hready) begin         // Address held until the slave is ready
      @(posedge tb_hclk20);
      #DRIVE_DLY;
    end
    @(posedge tb_hclk20);
    #DRIVE_DLY;
    htrans = HTRANS_IDLE;
    hwdata = wdata;               // Data phase, held until the next one
    while (!hready) begin
      @(posedge tb_hclk20);
      #DRIVE_DLY;
    end
  endtask

  // Pin or interrupt compare in the next cycle
  task automatic pin_check(input logic [2:0] kind, input hdata_t exp,
                           input logic [8*NAME_BYTES-1:0] name);
    chk_kind = kind;
    chk_exp  = exp;
    chk_name = name;
    pin_chk  = 1'b1;
    @(posedge tb_hclk20);
    #DRIVE_DLY;
    pin_chk = 1'b0;
  endtask

  task automatic run_command(input int i);
    if (cmd_op[i] == "wr") begin
      ahb_transfer(cmd_addr[i], 1'b1, HSIZE_WORD, cmd_data[i], K_WR, '0, cmd_name[i]);
    end else if (cmd_op[i] == "rd") begin
      ahb_transfer(cmd_addr[i], 1'b0, HSIZE_WORD, '0, K_RD, cmd_exp[i], cmd_name[i]);
    end else if (cmd_op[i] == "ew") begin  // Expected column is HSIZE here
      ahb_transfer(cmd_addr[i], 1'b1, hsize_t'(cmd_exp[i]), cmd_data[i], K_ERR, '0,
                   cmd_name[i]);
    end else if (cmd_op[i] == "er") begin
      ahb_transfer(cmd_addr[i], 1'b0, hsize_t'(cmd_exp[i]), '0, K_ERR, '0, cmd_name[i]);
    end else if (cmd_op[i] == "drive") begin
      gpio_in = cmd_data[i][GPIO_WIDTH-1:0];
    end else if (cmd_op[i] == "wait") begin
      repeat (cmd_data[i]) begin
        @(posedge tb_hclk20);
        #DRIVE_DLY;
      end
    end else if (cmd_op[i] == "pins") begin
      pin_check(K_PINS, cmd_exp[i], cmd_name[i]);
    end else if (cmd_op[i] == "irq") begin
      pin_check(K_IRQ, cmd_exp[i], cmd_name[i]);
    end else begin
      $display("Unknown command %s in stimulus entry %0d", cmd_op[i], i);
      bad_cmds++;
    end
  endtask

  // ==========================================================================
  // Main sequence and watchdog
  // ==========================================================================
  initial begin : main_seq
    logic load_ok;
    int   idx;
    hresetn20 = 1'b0;
    haddr     = '0;
    htrans    = HTRANS_IDLE;
    hsize     = HSIZE_WORD;
    hwrite    = 1'b0;
    hwdata    = '0;
    gpio_in   = '0;
    chk_kind  = K_RD;
    chk_exp   = '0;
    chk_name  = '0;
    pin_chk   = 1'b0;
    load_stimulus(load_ok);
    if (load_ok) begin
      wd_limit = RESET_CYCLES + 20 * n_cmds + wait_total;
      repeat (RESET_CYCLES) @(posedge tb_hclk20);
      #DRIVE_DLY;
      hresetn20 = 1'b1;
      for (idx = 0; idx < n_cmds; idx++) begin
        run_command(idx);
      end
      repeat (2) @(posedge tb_hclk20);  // Let the last compare land
      $display("Tests run: %0d, failed: %0d, bad commands: %0d",
               n_tests, n_errors, bad_cmds);
      if (n_errors == 0 && bad_cmds == 0 && n_tests > 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
    end else begin
      $display("Stimulus file is missing, empty or malformed");
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (wd_limit != 0);
    repeat (wd_limit) @(posedge tb_hclk20);
    $display("Watchdog expired after %0d cycles, the run did not finish", wd_limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/apb_subsystem_stimulus.txt
# op addr data expected name; ew/er put HSIZE in the expected column
# drive/wait use data; pins expects {oe_n,out}; irq expects {timer,gpio}
wr    00000000 1234a5a5 00000000 gpio_out_wr
rd    00000000 00000000 0000a5a5 gpio_out_rd
wr    00000004 ffff00f0 00000000 gpio_oe_wr
rd    00000004 00000000 000000f0 gpio_oe_rd
pins  00000000 00000000 ff0fa5a5 gpio_pins
wr    00000104 0001beef 00000000 tmr_load_wr
rd    00000104 00000000 0000beef tmr_load_rd
er    00000200 00000000 00000002 unmapped_rd
ew    00000200 00001111 00000002 unmapped_wr
ew    00000000 00000000 00000001 halfword_wr
er    00000104 00000000 00000001 halfword_rd
rd    00000000 00000000 0000a5a5 gpio_out_kept
rd    00000104 00000000 0000beef tmr_load_kept
irq   00000000 00000000 00000000 irq_idle
drive 00000000 00000005 00000000 set_pins
wait  00000000 00000004 00000000 sync_wait
rd    00000008 00000000 00000005 gpio_in_rd
rd    0000000c 00000000 00000005 gpio_stat_rd
irq   00000000 00000000 00000000 gpio_irq_masked
wr    00000010 00000004 00000000 gpio_mask_wr
rd    00000010 00000000 00000004 gpio_mask_rd
irq   00000000 00000000 00000001 gpio_irq_on
wr    0000000c 00000004 00000000 gpio_stat_clr
rd    0000000c 00000000 00000001 gpio_stat_rd2
irq   00000000 00000000 00000000 gpio_irq_off
wr    00000104 00000014 00000000 tmr_load20
wr    00000100 00000001 00000000 tmr_start
wait  00000000 00000028 00000000 tmr_run
rd    0000010c 00000000 00000001 tmr_stat_set
irq   00000000 00000000 00000002 tmr_irq_on
rd    00000108 00000000 00000000 tmr_count_zero
rd    00000100 00000000 00000000 tmr_en_cleared
wr    0000010c 00000001 00000000 tmr_stat_clr
irq   00000000 00000000 00000000 tmr_irq_off
wr    00000100 00000003 00000000 tmr_autoreload
wr    0000010c 00000001 00000000 tmr_stat_clr2
wait  00000000 00000018 00000000 tmr_reload_run
irq   00000000 00000000 00000002 tmr_irq_again
rd    00000100 00000000 00000003 tmr_en_kept

//--- files.f
source/apb_ss_bus_pkg.sv
source/apb_ss_periph_pkg.sv
source/ahb_to_apb_bridge.sv
source/apb_gpio.sv
source/apb_timer.sv
source/apb_subsystem.sv
verif/apb_subsystem_checker.sv
verif/apb_subsystem_tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the subsystem testbench with Verilator
# Exit status is 0 only when the pass message appears in the output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module apb_subsystem_tb_top -f files.f \
  --Mdir obj_dir -o apb_subsystem_sim

out=$(./obj_dir/apb_subsystem_sim || true)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
